//--- common/board_io_pkg.sv
/*
 * board_io shared definitions
 * link command codes, core identifier, register widths and the
 * fixed-point weights of the RGB to YPbPr conversion
 */

package board_io_pkg;

  ////////////////////////////////////////////////////////////
  // host link
  ////////////////////////////////////////////////////////////

  localparam logic [7:0] CORE_ID    = 8'ha5;  // aga core id, sent in byte 0

  localparam logic [7:0] CMD_JOY0   = 8'h02;  // joystick 0 word
  localparam logic [7:0] CMD_JOY1   = 8'h03;  // joystick 1 word
  localparam logic [7:0] CMD_JOY2   = 8'h10;  // joystick 2 word
  localparam logic [7:0] CMD_JOY3   = 8'h11;  // joystick 3 word
  localparam logic [7:0] CMD_MOUSE  = 8'h04;  // mouse movement bytes
  localparam logic [7:0] CMD_KBD    = 8'h05;  // keyboard scancodes
  localparam logic [7:0] CMD_CONFIG = 8'h14;  // core config byte

  ////////////////////////////////////////////////////////////
  // host registers
  ////////////////////////////////////////////////////////////

  localparam int JOY_W  = 16;  // [fire7:fire,up,down,left,right]
  localparam int CONF_W = 4;

  localparam int CONF_BIT_15KHZ    = 0;  // scandoubler off
  localparam int CONF_BIT_YPBPR    = 1;  // component output
  localparam int CONF_BIT_NO_CSYNC = 2;  // keep separate syncs in ypbpr

  localparam logic [1:0] KMS_TYPE_MOUSE = 2'd0;
  localparam logic [1:0] KMS_TYPE_KBD   = 2'd1;

  ////////////////////////////////////////////////////////////
  // video
  ////////////////////////////////////////////////////////////

  localparam int RGB_W = 8;  // core colour depth
  localparam int VGA_W = 6;  // resistor dac depth on the board

  // weights scaled by 256
  localparam int signed Y_R  = 77;
  localparam int signed Y_G  = 150;
  localparam int signed Y_B  = 29;
  localparam int signed PB_R = -43;
  localparam int signed PB_G = -85;
  localparam int signed PB_B = 128;
  localparam int signed PR_R = 128;
  localparam int signed PR_G = -107;
  localparam int signed PR_B = -21;

  localparam int signed CHROMA_OFS = 128;  // mid-scale for pb/pr

endpackage

//--- spi_link/spi_link_decode.sv
`timescale 1ns/1ps
/*
 * host SPI link receiver
 * syncs the SPI pins into clk_28, builds bytes and frames commands,
 * answers byte 0 with the core id and steers the shared data-out pin
 */

module spi_link_decode (
  input  logic       clk_28,
  input  logic       reset,
  input  logic       spi_sck,
  input  logic       spi_ss_io,   // user io select, active low
  input  logic       spi_di,
  input  logic       spi_ss2,     // core fpga select
  input  logic       spi_ss3,     // core osd select
  input  logic       core_sdo,
  output logic       spi_do,
  output logic       spi_do_oe,
  output logic       byte_valid,
  output logic [7:0] rx_byte,
  output logic [7:0] cmd,
  output logic [1:0] byte_idx
);

  logic       sck_meta, sck_s, sck_d;  // sck sync chain
  logic       ss_meta, ss_s;
  logic       di_meta, di_s;
  logic       sck_rise, sck_fall;      // registered edge strobes
  logic [2:0] bit_cnt;
  logic [1:0] byte_cnt;                // saturates at 3
  logic [7:0] rx_next;
  logic [7:0] tx_shift;
  logic       link_do;

  ////////////////////////////////////////////////////////////
  // pin synchronisers and edge detect
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_28) begin
    if (reset) begin
      sck_meta <= 1'b0;
      sck_s    <= 1'b0;
      sck_d    <= 1'b0;
      ss_meta  <= 1'b1;  // idle deselected
      ss_s     <= 1'b1;
      di_meta  <= 1'b0;
      di_s     <= 1'b0;
      sck_rise <= 1'b0;
      sck_fall <= 1'b0;
    end else begin
      sck_meta <= spi_sck;
      sck_s    <= sck_meta;
      sck_d    <= sck_s;
      ss_meta  <= spi_ss_io;
      ss_s     <= ss_meta;
      di_meta  <= spi_di;
      di_s     <= di_meta;
      sck_rise <= sck_s & ~sck_d;  // mode 0 sample edge
      sck_fall <= ~sck_s & sck_d;  // mode 0 shift edge
    end
  end

  ////////////////////////////////////////////////////////////
  // receive side
  ////////////////////////////////////////////////////////////

  assign rx_next = {rx_byte[6:0], di_s};  // msb first

  always_ff @(posedge clk_28) begin
    if (reset) begin
      bit_cnt    <= '0;
      byte_cnt   <= '0;
      byte_idx   <= '0;
      byte_valid <= 1'b0;
    end else begin
      byte_valid <= 1'b0;  // single cycle pulse
      if (ss_s) begin
        bit_cnt  <= '0;  // frame ends, restart at byte 0
        byte_cnt <= '0;
      end else if (sck_rise) begin
        bit_cnt <= bit_cnt + 3'd1;
        if (bit_cnt == 3'd7) begin
          byte_idx   <= byte_cnt;
          byte_valid <= (byte_cnt != 2'd0);  // byte 0 is the command
          if (byte_cnt != 2'd3)
            byte_cnt <= byte_cnt + 2'd1;
        end
      end
    end
  end

  // shifter and command latch
  always_ff @(posedge clk_28) begin
    if (!ss_s && sck_rise) begin
      rx_byte <= rx_next;
      if (bit_cnt == 3'd7 && byte_cnt == 2'd0)
        cmd <= rx_next;  // held for the rest of the frame
    end
  end

  ////////////////////////////////////////////////////////////
  // transmit side and data-out mux
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_28) begin
    if (reset || ss_s)
      tx_shift <= board_io_pkg::CORE_ID;  // msb ready before first rise
    else if (sck_fall)
      tx_shift <= {tx_shift[6:0], 1'b0};
  end

  assign link_do = (byte_cnt == 2'd0) ? tx_shift[7] : 1'b0;  // id in byte 0 only

  // link wins, then the core, else released
  assign spi_do    = !spi_ss_io ? link_do :
                     (!spi_ss2 || !spi_ss3) ? core_sdo : 1'b0;
  assign spi_do_oe = !spi_ss_io || !spi_ss2 || !spi_ss3;

  // bytes only come out of an open frame
  a_valid_in_frame : assert property (@(posedge clk_28) disable iff (reset)
    byte_valid |-> !ss_s)
    else $error("byte_valid outside of a frame");

  // one pulse per completed byte
  a_valid_single : assert property (@(posedge clk_28) disable iff (reset)
    byte_valid |=> !byte_valid)
    else $error("byte_valid held for more than one cycle");

endmodule

//--- spi_link/host_reg_exec.sv
`timescale 1ns/1ps
/*
 * host register file
 * runs decoded link bytes into joystick words, core config and
 * keyboard/mouse byte strobes
 */

module host_reg_exec (
  input  logic                            clk_28,
  input  logic                            reset,
  input  logic                            byte_valid,
  input  logic [7:0]                      rx_byte,
  input  logic [7:0]                      cmd,
  input  logic [1:0]                      byte_idx,
  output logic [board_io_pkg::JOY_W-1:0]  joy0_n,
  output logic [board_io_pkg::JOY_W-1:0]  joy1_n,
  output logic [board_io_pkg::JOY_W-1:0]  joy2_n,
  output logic [board_io_pkg::JOY_W-1:0]  joy3_n,
  output logic [board_io_pkg::CONF_W-1:0] core_config,
  output logic                            scan_15khz_n,
  output logic [7:0]                      kbd_mouse_data,
  output logic [1:0]                      kbd_mouse_type,
  output logic                            kbd_mouse_strobe
);

  logic [board_io_pkg::JOY_W-1:0] joy [4];  // active high copies
  logic [1:0]                     joy_sel;
  logic                           joy_hit;
  logic                           kms_hit;

  ////////////////////////////////////////////////////////////
  // command decode
  ////////////////////////////////////////////////////////////

  always_comb begin
    joy_hit = 1'b1;
    joy_sel = 2'd0;
    case (cmd)
      board_io_pkg::CMD_JOY0: joy_sel = 2'd0;
      board_io_pkg::CMD_JOY1: joy_sel = 2'd1;
      board_io_pkg::CMD_JOY2: joy_sel = 2'd2;
      board_io_pkg::CMD_JOY3: joy_sel = 2'd3;
      default:                joy_hit = 1'b0;  // not a joystick command
    endcase
  end

  assign kms_hit = (cmd == board_io_pkg::CMD_KBD) || (cmd == board_io_pkg::CMD_MOUSE);

  ////////////////////////////////////////////////////////////
  // registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_28) begin
    if (reset) begin
      for (int i = 0; i < 4; i++)
        joy[i] <= '0;  // nothing pressed
    end else if (byte_valid && joy_hit) begin
      if (byte_idx == 2'd1)
        joy[joy_sel][7:0] <= rx_byte;  // low byte first
      else if (byte_idx == 2'd2)
        joy[joy_sel][board_io_pkg::JOY_W-1:8] <= rx_byte;
    end
  end

  always_ff @(posedge clk_28) begin
    if (reset)
      core_config <= '0;  // 31khz rgb, separate syncs
    else if (byte_valid && cmd == board_io_pkg::CMD_CONFIG && byte_idx == 2'd1)
      core_config <= rx_byte[board_io_pkg::CONF_W-1:0];
  end

  // every data byte of a kbd/mouse frame goes out with its own strobe
  always_ff @(posedge clk_28) begin
    if (reset)
      kbd_mouse_strobe <= 1'b0;
    else
      kbd_mouse_strobe <= byte_valid && kms_hit;
  end

  always_ff @(posedge clk_28) begin
    if (byte_valid && kms_hit) begin
      kbd_mouse_data <= rx_byte;
      kbd_mouse_type <= (cmd == board_io_pkg::CMD_KBD) ? board_io_pkg::KMS_TYPE_KBD :
                                                         board_io_pkg::KMS_TYPE_MOUSE;
    end
  end

  assign joy0_n       = ~joy[0];  // core wants active low
  assign joy1_n       = ~joy[1];
  assign joy2_n       = ~joy[2];
  assign joy3_n       = ~joy[3];
  assign scan_15khz_n = ~core_config[board_io_pkg::CONF_BIT_15KHZ];

  a_strobe_single : assert property (@(posedge clk_28) disable iff (reset)
    kbd_mouse_strobe |=> !kbd_mouse_strobe)
    else $error("kbd_mouse_strobe held for more than one cycle");

endmodule

//--- video/video_out_stage.sv
`timescale 1ns/1ps
/*
 * video output stage
 * optional RGB to YPbPr with composite sync, then cut to the board
 * dac width and registered toward the pins, two cycles in total
 */

module video_out_stage (
  input  logic                           clk_28,
  input  logic                           reset,
  input  logic [board_io_pkg::RGB_W-1:0] red,
  input  logic [board_io_pkg::RGB_W-1:0] green,
  input  logic [board_io_pkg::RGB_W-1:0] blue,
  input  logic                           hsync_n,
  input  logic                           vsync_n,
  input  logic                           ypbpr,     // component mode
  input  logic                           no_csync,  // keep syncs apart in ypbpr
  output logic [board_io_pkg::VGA_W-1:0] vga_r,
  output logic [board_io_pkg::VGA_W-1:0] vga_g,
  output logic [board_io_pkg::VGA_W-1:0] vga_b,
  output logic                           vga_hs,
  output logic                           vga_vs
);

  localparam int RW = board_io_pkg::RGB_W;
  localparam int VW = board_io_pkg::VGA_W;

  logic [17:0]        y_sum;            // always positive
  logic signed [17:0] pb_sum, pr_sum;
  logic [RW-1:0]      y_val, pb_val, pr_val;
  logic               csync_n;
  logic [RW-1:0]      s1_r, s1_g, s1_b;  // conversion stage
  logic               s1_hs, s1_vs;

  ////////////////////////////////////////////////////////////
  // colour conversion
  ////////////////////////////////////////////////////////////

  assign y_sum  = 18'(board_io_pkg::Y_R * red + board_io_pkg::Y_G * green
                      + board_io_pkg::Y_B * blue);
  assign pb_sum = 18'(board_io_pkg::PB_R * $signed({1'b0, red})
                      + board_io_pkg::PB_G * $signed({1'b0, green})
                      + board_io_pkg::PB_B * $signed({1'b0, blue}));
  assign pr_sum = 18'(board_io_pkg::PR_R * $signed({1'b0, red})
                      + board_io_pkg::PR_G * $signed({1'b0, green})
                      + board_io_pkg::PR_B * $signed({1'b0, blue}));

  assign y_val  = y_sum[15:8];  // /256
  assign pb_val = RW'(board_io_pkg::CHROMA_OFS + (pb_sum >>> 8));  // wraps mod 256
  assign pr_val = RW'(board_io_pkg::CHROMA_OFS + (pr_sum >>> 8));

  assign csync_n = hsync_n & vsync_n;  // both active low

  ////////////////////////////////////////////////////////////
  // stage 1 and stage 2 registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_28) begin
    if (reset) begin
      s1_r  <= '0;
      s1_g  <= '0;
      s1_b  <= '0;
      s1_hs <= 1'b1;
      s1_vs <= 1'b1;
    end else if (ypbpr) begin
      s1_r  <= pr_val;  // pr on red
      s1_g  <= y_val;   // luma on green
      s1_b  <= pb_val;  // pb on blue
      s1_hs <= no_csync ? hsync_n : csync_n;
      s1_vs <= no_csync ? vsync_n : 1'b1;  // vs parked high with csync
    end else begin
      s1_r  <= red;
      s1_g  <= green;
      s1_b  <= blue;
      s1_hs <= hsync_n;
      s1_vs <= vsync_n;
    end
  end

  always_ff @(posedge clk_28) begin
    if (reset) begin
      vga_r  <= '0;
      vga_g  <= '0;
      vga_b  <= '0;
      vga_hs <= 1'b1;
      vga_vs <= 1'b1;
    end else begin
      vga_r  <= s1_r[RW-1 -: VW];  // drop the lsbs
      vga_g  <= s1_g[RW-1 -: VW];
      vga_b  <= s1_b[RW-1 -: VW];
      vga_hs <= s1_hs;
      vga_vs <= s1_vs;
    end
  end

  // the mode seen at stage 1 reaches the pins one cycle later
  a_csync_vs_high : assert property (@(posedge clk_28) disable iff (reset)
    (ypbpr && !no_csync) |-> ##2 vga_vs)
    else $error("vga_vs toggled in ypbpr mode with composite sync");

endmodule

//--- design/board_io_top.sv
`timescale 1ns/1ps
/*
 * board_io top level
 * host SPI link, host register file and video output stage
 */

module board_io_top (
  input  logic                            clk_28,
  input  logic                            reset,
  input  logic                            spi_sck,
  input  logic                            spi_ss_io,
  input  logic                            spi_di,
  input  logic                            spi_ss2,
  input  logic                            spi_ss3,
  input  logic                            core_sdo,
  input  logic [board_io_pkg::RGB_W-1:0]  red,
  input  logic [board_io_pkg::RGB_W-1:0]  green,
  input  logic [board_io_pkg::RGB_W-1:0]  blue,
  input  logic                            hsync_n,
  input  logic                            vsync_n,
  output logic                            spi_do,     // board wrapper builds the tristate
  output logic                            spi_do_oe,
  output logic [board_io_pkg::JOY_W-1:0]  joy0_n,
  output logic [board_io_pkg::JOY_W-1:0]  joy1_n,
  output logic [board_io_pkg::JOY_W-1:0]  joy2_n,
  output logic [board_io_pkg::JOY_W-1:0]  joy3_n,
  output logic                            scan_15khz_n,
  output logic [7:0]                      kbd_mouse_data,
  output logic [1:0]                      kbd_mouse_type,
  output logic                            kbd_mouse_strobe,
  output logic [board_io_pkg::VGA_W-1:0]  vga_r,
  output logic [board_io_pkg::VGA_W-1:0]  vga_g,
  output logic [board_io_pkg::VGA_W-1:0]  vga_b,
  output logic                            vga_hs,
  output logic                            vga_vs
);

  logic                            byte_valid;
  logic [7:0]                      rx_byte;
  logic [7:0]                      cmd;
  logic [1:0]                      byte_idx;
  logic [board_io_pkg::CONF_W-1:0] core_config;

  ////////////////////////////////////////////////////////////
  // host link
  ////////////////////////////////////////////////////////////

  spi_link_decode spi_link_decode_i (
    .clk_28(clk_28), .reset(reset),
    .spi_sck(spi_sck), .spi_ss_io(spi_ss_io), .spi_di(spi_di),
    .spi_ss2(spi_ss2), .spi_ss3(spi_ss3), .core_sdo(core_sdo),
    .spi_do(spi_do), .spi_do_oe(spi_do_oe),
    .byte_valid(byte_valid), .rx_byte(rx_byte), .cmd(cmd), .byte_idx(byte_idx)
  );

  host_reg_exec host_reg_exec_i (
    .clk_28(clk_28), .reset(reset),
    .byte_valid(byte_valid), .rx_byte(rx_byte), .cmd(cmd), .byte_idx(byte_idx),
    .joy0_n(joy0_n), .joy1_n(joy1_n), .joy2_n(joy2_n), .joy3_n(joy3_n),
    .core_config(core_config), .scan_15khz_n(scan_15khz_n),
    .kbd_mouse_data(kbd_mouse_data), .kbd_mouse_type(kbd_mouse_type),
    .kbd_mouse_strobe(kbd_mouse_strobe)
  );

  ////////////////////////////////////////////////////////////
  // video
  ////////////////////////////////////////////////////////////

  video_out_stage video_out_stage_i (
    .clk_28(clk_28), .reset(reset),
    .red(red), .green(green), .blue(blue), .hsync_n(hsync_n), .vsync_n(vsync_n),
    .ypbpr(core_config[board_io_pkg::CONF_BIT_YPBPR]),        // from host config
    .no_csync(core_config[board_io_pkg::CONF_BIT_NO_CSYNC]),
    .vga_r(vga_r), .vga_g(vga_g), .vga_b(vga_b), .vga_hs(vga_hs), .vga_vs(vga_vs)
  );

endmodule

//--- tb/board_io_tb_tasks.svh
/*
 * board_io testbench helpers
 * SPI mode 0 host transfers, core video drive and the
 * reference RGB to YPbPr conversion for the video pins
 */

`ifndef BOARD_IO_TB_TASKS_SVH
`define BOARD_IO_TB_TASKS_SVH

////////////////////////////////////////////////////////////
// host SPI link
////////////////////////////////////////////////////////////

task automatic shift_byte(input logic [7:0] b, input bit id_byte);
  int         bv_before;
  logic [7:0] id_rx;
  bv_before = bv_count;
  id_rx     = '0;
  for (int i = 7; i >= 0; i--) begin
    @(negedge clk_28);
    spi_sck = 1'b0;
    spi_di  = b[i];                       // msb first
    repeat (SCK_HALF) @(negedge clk_28);
    if (id_byte) begin
      id_rx[i] = spi_do;                  // host samples before the rise
      assert (spi_do_oe) else note_error("spi_do_oe low during a link transfer");
    end
    spi_sck = 1'b1;
    repeat (SCK_HALF - 1) @(negedge clk_28);  // byte_valid lands in here
  end
  if (id_byte)
    assert (id_rx == board_io_pkg::CORE_ID)
      else note_error($sformatf("core id read as %h", id_rx));
  assert (bv_count == bv_before + (id_byte ? 0 : 1))
    else note_error($sformatf("%0d byte_valid pulses for one byte", bv_count - bv_before));
endtask

task automatic spi_transfer();
  @(negedge clk_28);
  spi_ss_io = 1'b0;
  repeat (4) @(negedge clk_28);         // select through the synchroniser
  for (int i = 0; i < tx_q.size(); i++)
    shift_byte(tx_q[i], i == 0);
  @(negedge clk_28);
  spi_sck = 1'b0;
  repeat (2) @(negedge clk_28);
  spi_ss_io = 1'b1;
  repeat (IDLE_CYC) @(negedge clk_28);
endtask

task automatic drive_core_sdo();
  @(negedge clk_28);
  spi_ss2 = 1'b0;                       // core fpga owns the pin
  repeat (16) begin
    @(negedge clk_28);
    core_sdo = 1'($random(seed));
  end
  @(negedge clk_28);
  spi_ss2 = 1'b1;
  spi_ss3 = 1'b0;                       // then the osd
  repeat (8) begin
    @(negedge clk_28);
    core_sdo = 1'($random(seed));
  end
  @(negedge clk_28);
  spi_ss3 = 1'b1;
  repeat (4) @(negedge clk_28);         // all idle so the pin is released
endtask

task automatic check_joysticks();
  assert (joy0_n == joy_exp[0])
    else note_error($sformatf("joy0_n %h, expected %h", joy0_n, joy_exp[0]));
  assert (joy1_n == joy_exp[1])
    else note_error($sformatf("joy1_n %h, expected %h", joy1_n, joy_exp[1]));
  assert (joy2_n == joy_exp[2])
    else note_error($sformatf("joy2_n %h, expected %h", joy2_n, joy_exp[2]));
  assert (joy3_n == joy_exp[3])
    else note_error($sformatf("joy3_n %h, expected %h", joy3_n, joy_exp[3]));
endtask

task automatic finish_test(input string name, input int errs_at_start);
  int errs;
  errs = err_cnt - errs_at_start;
  tests_run++;
  if (errs == 0) begin
    $display("test %-26s ok", name);
  end else begin
    tests_failed++;
    $display("test %-26s FAILED, %0d errors", name, errs);
  end
endtask

////////////////////////////////////////////////////////////
// video
////////////////////////////////////////////////////////////

task automatic drive_pixels(input int n);
  for (int i = 0; i < n; i++) begin
    @(negedge clk_28);
    red     = 8'($random(seed));
    green   = 8'($random(seed));
    blue    = 8'($random(seed));
    hsync_n = ($random(seed) & 3) != 0;  // mostly inactive
    vsync_n = ($random(seed) & 3) != 0;
    vid_chk = 1'b1;
  end
  repeat (4) @(negedge clk_28);         // last pixels reach the pins
  vid_chk = 1'b0;
endtask

// {r, g, b, hs, vs} as the pins should show them
function automatic logic [19:0] expected_pins(input logic [7:0] r, input logic [7:0] g,
                                              input logic [7:0] b, input logic hs,
                                              input logic vs, input logic [3:0] conf);
  int         ri, gi, bi;
  int         y, pb, pr;
  logic [7:0] c_r, c_g, c_b;
  logic       s_h, s_v;
  ri = r;                               // signed maths from here on
  gi = g;
  bi = b;
  c_r = r;
  c_g = g;
  c_b = b;
  s_h = hs;
  s_v = vs;
  if (conf[board_io_pkg::CONF_BIT_YPBPR]) begin
    y  = (board_io_pkg::Y_R * ri + board_io_pkg::Y_G * gi + board_io_pkg::Y_B * bi) >>> 8;
    pb = board_io_pkg::CHROMA_OFS
         + ((board_io_pkg::PB_R * ri + board_io_pkg::PB_G * gi + board_io_pkg::PB_B * bi) >>> 8);
    pr = board_io_pkg::CHROMA_OFS
         + ((board_io_pkg::PR_R * ri + board_io_pkg::PR_G * gi + board_io_pkg::PR_B * bi) >>> 8);
    c_r = 8'(pr);                       // modulo 256
    c_g = 8'(y);
    c_b = 8'(pb);
    if (!conf[board_io_pkg::CONF_BIT_NO_CSYNC]) begin
      s_h = hs & vs;                    // composite on hs
      s_v = 1'b1;
    end
  end
  return {c_r[7:2], c_g[7:2], c_b[7:2], s_h, s_v};
endfunction

`endif

//--- tb/board_io_tb.sv
`timescale 1ns/1ps
/*
 * board_io testbench
 * drives the host SPI link, the core SPI output and the core video,
 * checks the register file and the video pins with assertions
 */

module board_io_tb;

  localparam int CLK_NS   = 40;
  localparam int SCK_HALF = 8;   // clk_28/16 on sck
  localparam int IDLE_CYC = 8;   // select idle between transfers
  localparam int N_XFER   = 10;
  localparam int N_BYTES  = 26;  // all bytes of all transfers
  localparam int N_PIX    = 64;  // per video mode
  localparam int XFER_CYC = 8 + IDLE_CYC;  // framing around the bytes
  localparam int TEST_CYC = 8 + N_BYTES * 16 * SCK_HALF + N_XFER * XFER_CYC
                            + 3 * (N_PIX + 5) + 64;  // slack for the mux test
  localparam int WATCHDOG_NS = 2 * TEST_CYC * CLK_NS;

  localparam logic [7:0] JOY_CMDS [4] = '{board_io_pkg::CMD_JOY0, board_io_pkg::CMD_JOY1,
                                          board_io_pkg::CMD_JOY2, board_io_pkg::CMD_JOY3};

  logic       clk_28 = 1'b0;
  logic       reset;
  logic       spi_sck, spi_ss_io, spi_di, spi_ss2, spi_ss3, core_sdo;
  logic [7:0] red, green, blue;
  logic       hsync_n, vsync_n;
  logic       spi_do, spi_do_oe;
  logic [15:0] joy0_n, joy1_n, joy2_n, joy3_n;
  logic       scan_15khz_n;
  logic [7:0] kbd_mouse_data;
  logic [1:0] kbd_mouse_type;
  logic       kbd_mouse_strobe;
  logic [5:0] vga_r, vga_g, vga_b;
  logic       vga_hs, vga_vs;

  integer     seed = 32'h64b7da5f;
  int         err_cnt = 0;
  int         tests_run = 0;
  int         tests_failed = 0;
  int         bv_count = 0;      // byte_valid pulses seen
  int         strobe_cnt = 0;
  logic [7:0] tx_q [$];          // bytes of the next transfer
  logic [9:0] kms_q [$];         // expected {type, data}
  logic [9:0] kms_exp;
  logic [15:0] joy_exp [4] = '{default: '1};  // active low pins
  logic [3:0] conf_sent = '0;
  logic       vid_chk = 1'b0;    // video inputs carry pixels

  task automatic note_error(input string msg);
    $display("[ERROR] t=%0t ns: %s", $time, msg);
    err_cnt++;
  endtask

  `include "board_io_tb_tasks.svh"

  always #(CLK_NS / 2) clk_28 = ~clk_28;

  board_io_top dut_i (
    .clk_28(clk_28), .reset(reset),
    .spi_sck(spi_sck), .spi_ss_io(spi_ss_io), .spi_di(spi_di),
    .spi_ss2(spi_ss2), .spi_ss3(spi_ss3), .core_sdo(core_sdo),
    .red(red), .green(green), .blue(blue), .hsync_n(hsync_n), .vsync_n(vsync_n),
    .spi_do(spi_do), .spi_do_oe(spi_do_oe),
    .joy0_n(joy0_n), .joy1_n(joy1_n), .joy2_n(joy2_n), .joy3_n(joy3_n),
    .scan_15khz_n(scan_15khz_n),
    .kbd_mouse_data(kbd_mouse_data), .kbd_mouse_type(kbd_mouse_type),
    .kbd_mouse_strobe(kbd_mouse_strobe),
    .vga_r(vga_r), .vga_g(vga_g), .vga_b(vga_b), .vga_hs(vga_hs), .vga_vs(vga_vs)
  );

  ////////////////////////////////////////////////////////////
  // assertions and monitors
  ////////////////////////////////////////////////////////////

  a_core_sdo : assert property (@(posedge clk_28) disable iff (reset)
    (spi_ss_io && (!spi_ss2 || !spi_ss3)) |-> (spi_do_oe && spi_do == core_sdo))
    else note_error("spi_do does not follow core_sdo");

  a_released : assert property (@(posedge clk_28) disable iff (reset)
    (spi_ss_io && spi_ss2 && spi_ss3) |-> !spi_do_oe)
    else note_error("spi_do_oe high with all selects idle");

  // pins show the pixel sampled two edges back
  a_video_pins : assert property (@(posedge clk_28) disable iff (reset)
    (vid_chk && $past(vid_chk, 2)) |->
      ({vga_r, vga_g, vga_b, vga_hs, vga_vs} ==
       expected_pins($past(red, 2), $past(green, 2), $past(blue, 2),
                     $past(hsync_n, 2), $past(vsync_n, 2), conf_sent)))
    else note_error($sformatf("video pins %h %h %h hs %b vs %b, conf %h",
                              vga_r, vga_g, vga_b, vga_hs, vga_vs, conf_sent));

  always @(posedge clk_28)
    if (!reset && dut_i.spi_link_decode_i.byte_valid)
      bv_count <= bv_count + 1;

  always @(negedge clk_28) begin
    if (!reset && kbd_mouse_strobe) begin
      strobe_cnt++;
      assert (kms_q.size() > 0) else note_error("kbd_mouse_strobe with no byte expected");
      if (kms_q.size() > 0) begin
        kms_exp = kms_q.pop_front();
        assert ({kbd_mouse_type, kbd_mouse_data} == kms_exp)
          else note_error($sformatf("kbd/mouse type %0d data %h, expected %0d %h",
                                    kbd_mouse_type, kbd_mouse_data, kms_exp[9:8], kms_exp[7:0]));
      end
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
    $display("Some tests failed");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    int          mark;
    logic [15:0] word;
    logic [7:0]  kb;
    logic [7:0]  conf_b [3];
    spi_sck   = 1'b0;  // mode 0 idle
    spi_ss_io = 1'b1;
    spi_di    = 1'b0;
    spi_ss2   = 1'b1;
    spi_ss3   = 1'b1;
    core_sdo  = 1'b0;
    red       = '0;
    green     = '0;
    blue      = '0;
    hsync_n   = 1'b1;
    vsync_n   = 1'b1;
    reset     = 1'b1;
    conf_b    = '{8'h01, 8'h02, 8'h06};  // rgb 15khz, ypbpr csync, ypbpr split
    repeat (8) @(negedge clk_28);
    reset = 1'b0;
    @(negedge clk_28);

    mark = err_cnt;
    check_joysticks();
    assert (scan_15khz_n) else note_error("scan_15khz_n low after reset");
    assert (!kbd_mouse_strobe) else note_error("kbd_mouse_strobe high after reset");
    assert (!spi_do_oe) else note_error("spi_do_oe high after reset");
    finish_test("reset state", mark);

    mark = err_cnt;
    tx_q = '{8'h00};  // command byte only
    spi_transfer();
    drive_core_sdo();
    finish_test("core id and spi_do mux", mark);

    mark = err_cnt;
    for (int k = 0; k < 4; k++) begin
      word = 16'($random(seed));
      tx_q = '{JOY_CMDS[k], word[7:0], word[15:8]};  // low byte first
      spi_transfer();
      joy_exp[k] = ~word;
      check_joysticks();
    end
    finish_test("joystick words", mark);

    mark = err_cnt;
    tx_q = '{board_io_pkg::CMD_KBD};
    for (int i = 0; i < 3; i++) begin
      kb = 8'($random(seed));
      tx_q.push_back(kb);
      kms_q.push_back({board_io_pkg::KMS_TYPE_KBD, kb});
    end
    spi_transfer();
    tx_q = '{board_io_pkg::CMD_MOUSE};
    for (int i = 0; i < 2; i++) begin
      kb = 8'($random(seed));
      tx_q.push_back(kb);
      kms_q.push_back({board_io_pkg::KMS_TYPE_MOUSE, kb});
    end
    spi_transfer();
    assert (kms_q.size() == 0) else note_error("kbd/mouse bytes missing a strobe");
    assert (strobe_cnt == 5) else note_error($sformatf("%0d strobes for 5 bytes", strobe_cnt));
    finish_test("keyboard and mouse bytes", mark);

    mark = err_cnt;
    for (int m = 0; m < 3; m++) begin
      tx_q = '{board_io_pkg::CMD_CONFIG, conf_b[m]};
      spi_transfer();
      conf_sent = conf_b[m][3:0];
      assert (scan_15khz_n == ~conf_b[m][board_io_pkg::CONF_BIT_15KHZ])
        else note_error($sformatf("scan_15khz_n %b for config %h", scan_15khz_n, conf_b[m]));
      drive_pixels(N_PIX);
    end
    finish_test("config and video", mark);

    $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, err_cnt);
    if (err_cnt == 0)
      $display("All tests passed");
    else
      $display("Some tests failed");
    $finish;
  end

endmodule

//--- verilog.f
+incdir+tb
common/board_io_pkg.sv
spi_link/spi_link_decode.sv
spi_link/host_reg_exec.sv
video/video_out_stage.sv
design/board_io_top.sv
tb/board_io_tb.sv
